/* design/hazardPkg.sv */
package hazardPkg;

	////////////////////////////////////////
	// Instruction field layout
	////////////////////////////////////////
	localparam int INSTR_W = 32;
	localparam int REG_W   = 5;
	localparam int OP_W    = 6;

	localparam int OP_POS = 26;
	localparam int RS_POS = 21;
	localparam int RT_POS = 16;
	localparam int RD_POS = 11;
	localparam int FN_POS = 0;

	localparam logic [REG_W-1:0] LINK_REG = 5'd31;

	// Primary opcodes
	localparam logic [OP_W-1:0] OP_RTYPE = 6'h00;
	localparam logic [OP_W-1:0] OP_J     = 6'h02;
	localparam logic [OP_W-1:0] OP_JAL   = 6'h03;
	localparam logic [OP_W-1:0] OP_BEQ   = 6'h04;
	localparam logic [OP_W-1:0] OP_BNE   = 6'h05;
	localparam logic [OP_W-1:0] OP_ADDI  = 6'h08;
	localparam logic [OP_W-1:0] OP_ANDI  = 6'h0c;
	localparam logic [OP_W-1:0] OP_ORI   = 6'h0d;
	localparam logic [OP_W-1:0] OP_LUI   = 6'h0f;
	localparam logic [OP_W-1:0] OP_LB    = 6'h20;
	localparam logic [OP_W-1:0] OP_LH    = 6'h21;
	localparam logic [OP_W-1:0] OP_LW    = 6'h23;
	localparam logic [OP_W-1:0] OP_SB    = 6'h28;
	localparam logic [OP_W-1:0] OP_SH    = 6'h29;
	localparam logic [OP_W-1:0] OP_SW    = 6'h2b;

	// R-type function codes
	localparam logic [OP_W-1:0] FN_JR    = 6'h08;
	localparam logic [OP_W-1:0] FN_MFHI  = 6'h10;
	localparam logic [OP_W-1:0] FN_MTHI  = 6'h11;
	localparam logic [OP_W-1:0] FN_MFLO  = 6'h12;
	localparam logic [OP_W-1:0] FN_MTLO  = 6'h13;
	localparam logic [OP_W-1:0] FN_MULT  = 6'h18;
	localparam logic [OP_W-1:0] FN_MULTU = 6'h19;
	localparam logic [OP_W-1:0] FN_DIV   = 6'h1a;
	localparam logic [OP_W-1:0] FN_DIVU  = 6'h1b;
	localparam logic [OP_W-1:0] FN_ADD   = 6'h20;
	localparam logic [OP_W-1:0] FN_SUB   = 6'h22;
	localparam logic [OP_W-1:0] FN_AND   = 6'h24;
	localparam logic [OP_W-1:0] FN_OR    = 6'h25;
	localparam logic [OP_W-1:0] FN_SLT   = 6'h2a;
	localparam logic [OP_W-1:0] FN_SLTU  = 6'h2b;
	// Branch on rs equal zero and link, resolved in D
	localparam logic [OP_W-1:0] FN_BEZAL = 6'h2c;

	////////////////////////////////////////
	// Pipeline timing
	////////////////////////////////////////
	localparam int TIME_W = 2;

	localparam logic [TIME_W-1:0] TNEW_NOW  = 2'd0;
	localparam logic [TIME_W-1:0] TNEW_ALU  = 2'd1;
	localparam logic [TIME_W-1:0] TNEW_LOAD = 2'd2;

	localparam logic [TIME_W-1:0] TUSE_BRANCH = 2'd0;
	localparam logic [TIME_W-1:0] TUSE_ALU    = 2'd1;
	localparam logic [TIME_W-1:0] TUSE_STORE  = 2'd2;
	localparam logic [TIME_W-1:0] TUSE_NONE   = 2'd3;

	// Forward mux selects for the D-stage operands
	localparam int FWD_W = 2;
	localparam logic [FWD_W-1:0] FWD_REGFILE = 2'd0;
	localparam logic [FWD_W-1:0] FWD_FROM_M  = 2'd1;
	localparam logic [FWD_W-1:0] FWD_FROM_E  = 2'd2;

	////////////////////////////////////////
	// APB register map
	////////////////////////////////////////
	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;
	localparam int CNT_W      = 32;

	localparam logic [APB_ADDR_W-1:0] ADDR_CTRL     = 8'h00;
	localparam logic [APB_ADDR_W-1:0] ADDR_STALLCNT = 8'h04;
	localparam logic [APB_ADDR_W-1:0] ADDR_ID       = 8'h08;

	localparam logic [APB_DATA_W-1:0] HAZARD_ID = 32'h4841_5a31;

endpackage

/* design/hazardRegs.sv */
`timescale 1ns/10ps

module hazardRegs import hazardPkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  logic [APB_DATA_W-1:0] pwdata,
	output logic [APB_DATA_W-1:0] prdata,
	input  logic                  stall,
	output logic                  fwdEnable
);

	logic             wrAccess;
	logic             rdAccess;
	logic             ctrlFwd;
	logic [CNT_W-1:0] stallCnt;

	// Write commits at the edge closing the access phase
	assign wrAccess = psel && penable && pwrite;
	assign rdAccess = psel && !pwrite;

	////////////////////////////////////////
	// CTRL
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrlFwd <= 1'b1;
		end else if (wrAccess && paddr == ADDR_CTRL) begin
			ctrlFwd <= pwdata[0];
		end
	end

	assign fwdEnable = ctrlFwd;

	////////////////////////////////////////
	// STALLCNT
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			stallCnt <= '0;
		end else if (wrAccess && paddr == ADDR_STALLCNT) begin
			// Any write clears, even in a stall cycle
			stallCnt <= '0;
		end else if (stall && stallCnt != '1) begin
			stallCnt <= stallCnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Read mux
	////////////////////////////////////////
	always_comb begin
		prdata = '0;
		if (rdAccess) begin
			case (paddr)
				ADDR_CTRL: begin
					prdata = {{(APB_DATA_W-1){1'b0}}, ctrlFwd};
				end
				ADDR_STALLCNT: begin
					prdata = APB_DATA_W'(stallCnt);
				end
				ADDR_ID: begin
					prdata = HAZARD_ID;
				end
				// Holes in the map read as zero
				default: begin
					prdata = '0;
				end
			endcase
		end
	end

endmodule

/* design/hazardTop.sv */
`timescale 1ns/10ps

module hazardTop import hazardPkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	// Pipeline side
	input  logic [INSTR_W-1:0]    instrD,
	input  logic [INSTR_W-1:0]    instrE,
	input  logic [INSTR_W-1:0]    instrM,
	input  logic                  judgeE,
	input  logic                  judgeM,
	output logic                  stall,
	output logic [FWD_W-1:0]      fwdRs,
	output logic [FWD_W-1:0]      fwdRt,
	// APB side
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  logic [APB_DATA_W-1:0] pwdata,
	output logic [APB_DATA_W-1:0] prdata
);

	logic [REG_W-1:0]  rsReg;
	logic [REG_W-1:0]  rtReg;
	logic [TIME_W-1:0] tuseRs;
	logic [TIME_W-1:0] tuseRt;
	logic [REG_W-1:0]  destE;
	logic [TIME_W-1:0] tnewE;
	logic [REG_W-1:0]  destM;
	logic [TIME_W-1:0] tnewM;
	logic              fwdEnable;

	operandUseDecode useDecode_i (
		.instr  (instrD),
		.rsReg  (rsReg),
		.rtReg  (rtReg),
		.tuseRs (tuseRs),
		.tuseRt (tuseRt)
	);

	// M runs the same table one cycle further along
	writeBackDecode #(.stageLag(0)) execDecode_i (
		.instr   (instrE),
		.judge   (judgeE),
		.destReg (destE),
		.tnew    (tnewE)
	);

	writeBackDecode #(.stageLag(1)) memDecode_i (
		.instr   (instrM),
		.judge   (judgeM),
		.destReg (destM),
		.tnew    (tnewM)
	);

	stallForwardLogic compare_i (
		.rsReg     (rsReg),
		.rtReg     (rtReg),
		.tuseRs    (tuseRs),
		.tuseRt    (tuseRt),
		.destE     (destE),
		.tnewE     (tnewE),
		.destM     (destM),
		.tnewM     (tnewM),
		.fwdEnable (fwdEnable),
		.stall     (stall),
		.fwdRs     (fwdRs),
		.fwdRt     (fwdRt)
	);

	hazardRegs regs_i (
		.clk       (clk),
		.rst       (rst),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.stall     (stall),
		.fwdEnable (fwdEnable)
	);

endmodule

/* design/operandUseDecode.sv */
`timescale 1ns/10ps

module operandUseDecode import hazardPkg::*; (
	input  logic [INSTR_W-1:0] instr,
	output logic [REG_W-1:0]   rsReg,
	output logic [REG_W-1:0]   rtReg,
	output logic [TIME_W-1:0]  tuseRs,
	output logic [TIME_W-1:0]  tuseRt
);

	logic [OP_W-1:0] opcode;
	logic [OP_W-1:0] funct;

	assign opcode = instr[OP_POS +: OP_W];
	assign funct  = instr[FN_POS +: OP_W];

	// Register fields are passed on as-is; Tuse says if they are read
	assign rsReg = instr[RS_POS +: REG_W];
	assign rtReg = instr[RT_POS +: REG_W];

	always_comb begin
		tuseRs = TUSE_NONE;
		tuseRt = TUSE_NONE;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU: begin
						tuseRs = TUSE_ALU;
						tuseRt = TUSE_ALU;
					end
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
						tuseRs = TUSE_ALU;
						tuseRt = TUSE_ALU;
					end
					FN_JR: begin
						tuseRs = TUSE_BRANCH;
					end
					FN_MTHI, FN_MTLO, FN_BEZAL: begin
						tuseRs = TUSE_ALU;
					end
					// mfhi/mflo read no GPR
					default: begin
						tuseRs = TUSE_NONE;
						tuseRt = TUSE_NONE;
					end
				endcase
			end

			OP_BEQ, OP_BNE: begin
				tuseRs = TUSE_BRANCH;
				tuseRt = TUSE_BRANCH;
			end

			OP_ADDI, OP_ANDI, OP_ORI: begin
				tuseRs = TUSE_ALU;
			end

			// Base address goes through the ALU
			OP_LW, OP_LH, OP_LB: begin
				tuseRs = TUSE_ALU;
			end

			// Store data is only needed in M
			OP_SW, OP_SH, OP_SB: begin
				tuseRs = TUSE_ALU;
				tuseRt = TUSE_STORE;
			end

			// lui, j, jal and unknown codes read nothing
			default: begin
				tuseRs = TUSE_NONE;
				tuseRt = TUSE_NONE;
			end
		endcase
	end

endmodule

/* design/stallForwardLogic.sv */
`timescale 1ns/10ps

module stallForwardLogic import hazardPkg::*; (
	input  logic [REG_W-1:0]  rsReg,
	input  logic [REG_W-1:0]  rtReg,
	input  logic [TIME_W-1:0] tuseRs,
	input  logic [TIME_W-1:0] tuseRt,
	input  logic [REG_W-1:0]  destE,
	input  logic [TIME_W-1:0] tnewE,
	input  logic [REG_W-1:0]  destM,
	input  logic [TIME_W-1:0] tnewM,
	input  logic              fwdEnable,
	output logic              stall,
	output logic [FWD_W-1:0]  fwdRs,
	output logic [FWD_W-1:0]  fwdRt
);

	// Index 0 is rs, index 1 is rt
	logic [REG_W-1:0]  srcReg  [2];
	logic [TIME_W-1:0] srcTuse [2];
	logic [FWD_W-1:0]  srcFwd  [2];
	logic [1:0]        srcStall;

	assign srcReg[0]  = rsReg;
	assign srcReg[1]  = rtReg;
	assign srcTuse[0] = tuseRs;
	assign srcTuse[1] = tuseRt;

	////////////////////////////////////////
	// Per-operand check
	////////////////////////////////////////
	for (genvar i = 0; i < 2; i++) begin : gSrc
		logic matchE;
		logic matchM;
		logic isRead;

		assign isRead = (srcReg[i] != '0) && (srcTuse[i] != TUSE_NONE);
		assign matchE = isRead && (srcReg[i] == destE);
		assign matchM = isRead && (srcReg[i] == destM);

		always_comb begin
			srcStall[i] = 1'b0;
			srcFwd[i]   = FWD_REGFILE;
			if (!fwdEnable) begin
				// Without bypass every pending write must retire first
				srcStall[i] = matchE || matchM;
			end else if ((matchE && tnewE > srcTuse[i]) ||
				(matchM && tnewM > srcTuse[i])) begin
				srcStall[i] = 1'b1;
			end else if (matchE && tnewE == TNEW_NOW) begin
				// Youngest producer wins
				srcFwd[i] = FWD_FROM_E;
			end else if (matchM && tnewM == TNEW_NOW) begin
				srcFwd[i] = FWD_FROM_M;
			end
		end
	end

	assign stall = |srcStall;
	assign fwdRs = srcFwd[0];
	assign fwdRt = srcFwd[1];

endmodule

/* design/writeBackDecode.sv */
`timescale 1ns/10ps

module writeBackDecode import hazardPkg::*; #(
	parameter int stageLag = 0
) (
	input  logic [INSTR_W-1:0] instr,
	input  logic               judge,
	output logic [REG_W-1:0]   destReg,
	output logic [TIME_W-1:0]  tnew
);

	logic [OP_W-1:0]   opcode;
	logic [OP_W-1:0]   funct;
	logic [REG_W-1:0]  rt;
	logic [REG_W-1:0]  rd;
	logic [TIME_W-1:0] baseTnew;

	assign opcode = instr[OP_POS +: OP_W];
	assign funct  = instr[FN_POS +: OP_W];
	assign rt     = instr[RT_POS +: REG_W];
	assign rd     = instr[RD_POS +: REG_W];

	////////////////////////////////////////
	// Destination and Tnew as seen from E
	////////////////////////////////////////
	always_comb begin
		destReg  = '0;
		baseTnew = TNEW_NOW;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU: begin
						destReg  = rd;
						baseTnew = TNEW_ALU;
					end
					FN_MFHI, FN_MFLO: begin
						destReg  = rd;
						baseTnew = TNEW_ALU;
					end
					// Link only taken when the condition held
					FN_BEZAL: begin
						destReg  = judge ? LINK_REG : '0;
						baseTnew = TNEW_NOW;
					end
					// HI/LO writers and jr leave the register file alone
					FN_JR, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MTHI, FN_MTLO: begin
						destReg  = '0;
						baseTnew = TNEW_NOW;
					end
					default: begin
						destReg  = '0;
						baseTnew = TNEW_NOW;
					end
				endcase
			end

			OP_ORI, OP_ADDI, OP_ANDI, OP_LUI: begin
				destReg  = rt;
				baseTnew = TNEW_ALU;
			end

			OP_LW, OP_LH, OP_LB: begin
				destReg  = rt;
				baseTnew = TNEW_LOAD;
			end

			// PC+8 is already known
			OP_JAL: begin
				destReg  = LINK_REG;
				baseTnew = TNEW_NOW;
			end

			OP_SW, OP_SH, OP_SB, OP_J, OP_BEQ, OP_BNE: begin
				destReg  = '0;
				baseTnew = TNEW_NOW;
			end

			default: begin
				destReg  = '0;
				baseTnew = TNEW_NOW;
			end
		endcase
	end

	// Each stage further down the pipe brings the result one cycle closer
	assign tnew = (int'(baseTnew) > stageLag) ? TIME_W'(int'(baseTnew) - stageLag) : '0;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the hazard unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module hazardTb -f tb.f -o hazardSim || exit 1
simOut="$(./obj_dir/hazardSim)"
echo "$simOut"
echo "$simOut" | grep -qx "Simulation completed successfully" && exit 0 || exit 1

/* tb.f */
design/hazardPkg.sv
design/operandUseDecode.sv
design/writeBackDecode.sv
design/stallForwardLogic.sv
design/hazardRegs.sv
design/hazardTop.sv
testbench/hazardTb.sv

/* testbench/hazardTb.sv */
`timescale 1ns/10ps

module hazardTb import hazardPkg::*; ();

	logic                  clk;
	logic                  rst;
	logic [INSTR_W-1:0]    instrD;
	logic [INSTR_W-1:0]    instrE;
	logic [INSTR_W-1:0]    instrM;
	logic                  judgeE;
	logic                  judgeM;
	logic                  stall;
	logic [FWD_W-1:0]      fwdRs;
	logic [FWD_W-1:0]      fwdRt;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [APB_DATA_W-1:0] pwdata;
	logic [APB_DATA_W-1:0] prdata;

	// One entry per test line
	string              qName[$];
	logic [INSTR_W-1:0] qD[$];
	logic [INSTR_W-1:0] qE[$];
	logic [INSTR_W-1:0] qM[$];
	logic               qJudgeE[$];
	logic               qJudgeM[$];
	logic               qFwdEn[$];
	logic               qStall[$];
	logic [FWD_W-1:0]   qFwdRs[$];
	logic [FWD_W-1:0]   qFwdRt[$];

	int   cycleCount = 0;
	int   cycleLimit = 0;
	int   testErrors = 0;
	int   passCount  = 0;
	int   failCount  = 0;
	int   expStalls  = 0;
	logic curFwdEn   = 1'b1;

	hazardTop dut_i (
		.clk     (clk),
		.rst     (rst),
		.instrD  (instrD),
		.instrE  (instrE),
		.instrM  (instrM),
		.judgeE  (judgeE),
		.judgeM  (judgeM),
		.stall   (stall),
		.fwdRs   (fwdRs),
		.fwdRt   (fwdRt),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog limit is set once the test file is loaded
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Reporting helpers
	////////////////////////////////////////
	task automatic reportMismatch(input string name, input string field,
		input logic [31:0] expVal, input logic [31:0] actVal);
		$display("Mismatch in %s: %s expected %0h, actual %0h", name, field, expVal, actVal);
		testErrors = testErrors + 1;
	endtask

	task automatic closeTest(input string name);
		if (testErrors == 0) begin
			passCount = passCount + 1;
			$display("PASS %s", name);
		end else begin
			failCount = failCount + 1;
			$display("FAIL %s", name);
		end
		testErrors = 0;
	endtask

	////////////////////////////////////////
	// APB transfers entered 1 ns after an edge
	////////////////////////////////////////
	task automatic apbWrite(input logic [APB_ADDR_W-1:0] addr, input logic [APB_DATA_W-1:0] data);
		psel    = 1'b1;
		pwrite  = 1'b1;
		penable = 1'b0;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apbRead(input logic [APB_ADDR_W-1:0] addr, output logic [APB_DATA_W-1:0] data);
		psel    = 1'b1;
		pwrite  = 1'b0;
		penable = 1'b0;
		paddr   = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#4;
		data = prdata;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbCheck(input string name, input logic [APB_ADDR_W-1:0] addr,
		input logic [APB_DATA_W-1:0] expVal);
		logic [APB_DATA_W-1:0] readVal;
		apbRead(addr, readVal);
		if (readVal !== expVal) begin
			reportMismatch(name, "prdata", expVal, readVal);
		end
		closeTest(name);
	endtask

	////////////////////////////////////////
	// One pipeline vector
	////////////////////////////////////////
	task automatic runVector(input int idx);
		if (qFwdEn[idx] != curFwdEn) begin
			apbWrite(ADDR_CTRL, {31'b0, qFwdEn[idx]});
			curFwdEn = qFwdEn[idx];
		end
		instrD = qD[idx];
		instrE = qE[idx];
		instrM = qM[idx];
		judgeE = qJudgeE[idx];
		judgeM = qJudgeM[idx];
		#4;
		if (stall !== qStall[idx]) begin
			reportMismatch(qName[idx], "stall", 32'(qStall[idx]), 32'(stall));
		end
		if (fwdRs !== qFwdRs[idx]) begin
			reportMismatch(qName[idx], "fwdRs", 32'(qFwdRs[idx]), 32'(fwdRs));
		end
		if (fwdRt !== qFwdRt[idx]) begin
			reportMismatch(qName[idx], "fwdRt", 32'(qFwdRt[idx]), 32'(fwdRt));
		end
		if (qStall[idx]) begin
			expStalls = expStalls + 1;
		end
		closeTest(qName[idx]);
		@(posedge clk);
		#1;
		// Bubbles keep the counter still between vectors
		instrD = '0;
		instrE = '0;
		instrM = '0;
		judgeE = 1'b0;
		judgeM = 1'b0;
	endtask

	task automatic loadTests(output int ok);
		int          fd;
		int          r;
		int          n;
		string       line;
		string       nameTmp;
		logic [31:0] f[9];
		ok = 1;
		fd = $fopen("testbench/hazardTests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test vector file");
			ok = 0;
		end else begin
			while (!$feof(fd)) begin
				r = $fgets(line, fd);
				if (r != 0 && line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", nameTmp,
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
					if (n == 10) begin
						qName.push_back(nameTmp);
						qD.push_back(f[0]);
						qE.push_back(f[1]);
						qM.push_back(f[2]);
						qJudgeE.push_back(f[3][0]);
						qJudgeM.push_back(f[4][0]);
						qFwdEn.push_back(f[5][0]);
						qStall.push_back(f[6][0]);
						qFwdRs.push_back(f[7][1:0]);
						qFwdRt.push_back(f[8][1:0]);
					end else begin
						$display("Malformed line in the test vector file: %s", line);
						ok = 0;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		int loadOk;
		rst     = 1'b1;
		instrD  = '0;
		instrE  = '0;
		instrM  = '0;
		judgeE  = 1'b0;
		judgeM  = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		loadTests(loadOk);
		if (loadOk == 0 || qD.size() == 0) begin
			$display("No usable test vectors were loaded");
			$display("Simulation failed");
			$finish;
		end else begin
			cycleLimit = 20 * qD.size() + 50;
			repeat (4) @(posedge clk);
			#1;
			rst = 1'b0;
			for (int i = 0; i < qD.size(); i++) begin
				runVector(i);
			end
			// Register block checks
			apbCheck("apbStallCount", ADDR_STALLCNT, APB_DATA_W'(expStalls));
			apbCheck("apbIdRead", ADDR_ID, HAZARD_ID);
			apbWrite(ADDR_CTRL, 32'h0);
			apbCheck("apbCtrlClear", ADDR_CTRL, 32'h0);
			apbWrite(ADDR_CTRL, 32'h1);
			apbCheck("apbCtrlSet", ADDR_CTRL, 32'h1);
			apbWrite(ADDR_STALLCNT, 32'hdead_beef);
			apbCheck("apbStallClear", ADDR_STALLCNT, 32'h0);
			apbCheck("apbUnmapped", 8'h0c, 32'h0);
			$display("Tests passed: %0d, failed: %0d", passCount, failCount);
			if (failCount == 0) begin
				$display("Simulation completed successfully");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

endmodule

/* testbench/hazardTests.txt */
# name instrD instrE instrM judgeE judgeM fwdEnable stall fwdRs fwdRt
# instructions in hex, fwd selects 0 regfile, 1 from M, 2 from E
fwdJalE 03e00008 0c000000 00000000 0 0 1 0 2 0
fwdAluM 00221820 00000000 00850820 0 0 1 0 1 0
fwdBothEWins 03e00008 0c000000 0c000000 0 0 1 0 2 0
fwdAluMRt 00221820 00000000 34820005 0 0 1 0 0 1
loadUseE 00221820 8c810000 00000000 0 0 1 1 0 0
storeDataLoadM ac810000 00000000 8ca10000 0 0 1 0 0 0
storeBaseLoadE ac220000 84810000 00000000 0 0 1 1 0 0
beqAluE 10220004 00850820 00000000 0 0 1 1 0 0
bneLoadM 14620004 00000000 8c820000 0 0 1 1 0 0
jrAluE 00a00008 34250001 00000000 0 0 1 1 0 0
beqAluM 10220004 00000000 00850820 0 0 1 0 1 0
zeroRegIgnored 00001820 8c800000 00850020 0 0 1 0 0 0
bezalTakenE 03e00008 0020002c 00000000 1 0 1 0 2 0
bezalNotTakenE 03e00008 0020002c 00000000 0 0 1 0 0 0
bezalNotTakenLoadM 03e00008 0020002c 8c9f0000 0 0 1 1 0 0
bezalTakenM 03e00008 00000000 0020002c 0 1 1 0 1 0
storeNoHazard 00221820 ac810000 ac220000 0 0 1 0 0 0
multMthiNoHazard 00221820 00220018 00400011 0 0 1 0 0 0
mfloFwdM 00221820 00000000 00001012 0 0 1 0 0 1
loadRtLuiRs 00221820 8c820000 3c011234 0 0 1 1 1 0
noFwdJalE 03e00008 0c000000 00000000 0 0 0 1 0 0
noFwdAluM 00221820 00000000 00850820 0 0 0 1 0 0
noFwdStoreLoadM ac810000 00000000 8ca10000 0 0 0 1 0 0
noFwdNoMatch 00221820 00a52020 00000000 0 0 0 0 0 0
noFwdZeroReg 00001820 8c800000 00000000 0 0 0 0 0 0
fwdReenabled 00221820 00000000 00850820 0 0 1 0 1 0
